/* vlog.f */
source/mac_op_pkg.sv
source/mac_types_pkg.sv
source/mac_sequencer.sv
source/mac_partial_product.sv
source/mac_accumulator.sv
source/mac_result_writer.sv
source/mac_unit.sv
dv/mac_unit_assertions.sv
dv/mac_unit_tb.sv

/* dv/mac_unit_input.txt */
# name op cc rm rs rh rn stall_n stall_at clr clr_at exp_rd exp_valid exp_nozero (hex)
# clr 0 none, 1 writeback, 2 ALU. Cycles count from the start cycle, which is cycle 0.
u_hi_zero_buf 15 1 00000002 00000003 00000000 00000000 0 0 0 0 00000000 1 0
u_lo_carry 14 1 00010000 00010000 00000000 00000005 0 0 0 0 00000005 1 0
u_hi_carry 15 1 ffffffff ffffffff 00000000 ffffffff 0 0 0 0 ffffffff 1 1
u_lo_max 14 1 ffffffff ffffffff ffffffff ffffffff 0 0 0 0 00000000 1 0
u_hi_addend 15 1 00001234 00010000 00000007 00000000 0 0 0 0 00000007 1 0
s_lo_neg 16 1 ffffffff 00000003 00000000 00000000 0 0 0 0 fffffffd 1 0
s_hi_neg 17 1 ffffffff 00000003 00000000 00000000 0 0 0 0 ffffffff 1 1
s_hi_min_sq 17 1 80000000 80000000 00000000 00000000 0 0 0 0 40000000 1 1
s_lo_min_max 16 1 80000000 7fffffff ffffffff ffffffff 0 0 0 0 7fffffff 1 0
stall_lo 14 1 00000010 00000010 00000000 00000000 3 2 0 0 00000100 1 0
stall_hi_add 17 1 fffffffe 00000002 00000000 00000004 2 5 0 0 00000000 1 1
clr_wb 14 1 00000001 00000001 00000000 00000000 0 0 1 3 00000000 0 0
hi_after_wb 15 1 00000001 00000001 00000002 00000000 0 0 0 0 00000002 1 0
lo_refill 14 1 00000002 00000002 00000000 00000000 0 0 0 0 00000004 1 0
clr_alu 16 1 00000005 00000005 00000000 00000000 0 0 2 2 00000000 0 0
hi_after_alu 15 1 00000000 00000000 00000009 00000000 0 0 0 0 00000009 1 0
lo_refill2 16 1 00000003 00000003 00000000 00000000 0 0 0 0 00000009 1 0
clr_in_stall 14 1 00000001 00000001 00000000 00000000 3 2 1 3 00000000 0 0
hi_after_stall 15 1 00000000 00000000 00000001 00000000 0 0 0 0 00000001 1 0
no_mul 0d 1 00000007 00000007 00000000 00000000 0 0 0 0 00000000 0 0
cc_low 14 0 00000007 00000007 00000000 00000000 0 0 0 0 00000000 0 0

/* dv/mac_unit_tb.sv */
// Multiply-accumulate unit testbench with vector file reader, driver, checker and watchdog.

`timescale 1ns/1ps
`default_nettype none

module mac_unit_tb
        import mac_op_pkg::*;
        import mac_types_pkg::*;
();

        localparam int    CLK_PERIOD        = 10;
        localparam int    RESET_CYCLES      = 5;
        localparam int    CYCLES_PER_VECTOR = 20;
        localparam int    BASE_LATENCY      = 5;       // Start cycle to result cycle.
        localparam int    SLACK_CYCLES      = 4;
        localparam string INPUT_FILE        = "dv/mac_unit_input.txt";
        localparam logic [1:0] CLR_NONE     = 2'd0;
        localparam logic [1:0] CLR_WB       = 2'd1;
        localparam logic [1:0] CLR_ALU      = 2'd2;

        // One line of the vector file, without its name.
        typedef struct packed {
                logic [4:0]  op;
                logic        cc;
                logic [31:0] rm;
                logic [31:0] rs;
                logic [31:0] rh;
                logic [31:0] rn;
                logic [7:0]  stall_n;
                logic [7:0]  stall_at;
                logic [1:0]  clr;
                logic [7:0]  clr_at;
                logic [31:0] exp_rd;
                logic [7:0]  exp_valid;
                logic        exp_nozero;
        } vector_t;

        logic          i_clk;
        logic          i_reset;
        logic          i_clear_from_writeback;
        logic          i_data_stall;
        logic          i_clear_from_alu;
        logic          i_cc_satisfied;
        mac_op_t       i_op;
        mac_operands_t i_operands;
        logic [31:0]   o_rd;
        logic          o_result_valid;
        logic          o_busy;
        logic          o_nozero;

        vector_t vectors[$];
        string   names[$];
        int      watchdog_cycles;
        logic    watchdog_armed = 1'b0;

        mac_unit UUT (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear_from_writeback (i_clear_from_writeback),
                .i_data_stall           (i_data_stall),
                .i_clear_from_alu       (i_clear_from_alu),
                .i_op                   (i_op),
                .i_cc_satisfied         (i_cc_satisfied),
                .i_operands             (i_operands),
                .o_rd                   (o_rd),
                .o_result_valid         (o_result_valid),
                .o_busy                 (o_busy),
                .o_nozero               (o_nozero)
        );

        initial
        begin
                i_clk = 1'b0;
                forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Failure reporting and comparison.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        task automatic abort_run(input string why);
                $display("%s", why);
                $display("Result: FAILED");
                $fatal(1, "Simulation stopped on the first error.");
        endtask

        task automatic compare(input string test, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
                if (expected !== actual)
                begin
                        abort_run($sformatf("[FAIL] %s %s: expected 'h%0h, actual 'h%0h",
                                            test, what, expected, actual));
                end
        endtask

        // A start needs a long multiply code and a passed condition.
        function automatic logic expect_start(input vector_t v);
                return v.cc && (mac_op_t'(v.op) inside {UMLALL, UMLALH, SMLALL, SMLALH});
        endfunction

        task automatic load_vectors();
                int          fd;
                int          count;
                string       line;
                string       name;
                logic [31:0] f_op, f_cc, f_rm, f_rs, f_rh, f_rn, f_sn, f_sa;
                logic [31:0] f_clr, f_ca, f_rd, f_valid, f_nz;
                vector_t     v;
                fd = $fopen(INPUT_FILE, "r");
                if (fd == 0)
                begin
                        abort_run("Cannot open the vector file.");
                end
                while (!$feof(fd))
                begin
                        line = "";
                        count = $fgets(line, fd);
                        if (line.len() < 2 || line.getc(0) == "#")
                        begin
                                continue;               // Blank or comment line.
                        end
                        count = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                        name, f_op, f_cc, f_rm, f_rs, f_rh, f_rn, f_sn,
                                        f_sa, f_clr, f_ca, f_rd, f_valid, f_nz);
                        if (count != 14)
                        begin
                                abort_run($sformatf("Malformed vector line: %s", line));
                        end
                        v = '{op: f_op[4:0], cc: f_cc[0], rm: f_rm, rs: f_rs, rh: f_rh,
                              rn: f_rn, stall_n: f_sn[7:0], stall_at: f_sa[7:0],
                              clr: f_clr[1:0], clr_at: f_ca[7:0], exp_rd: f_rd,
                              exp_valid: f_valid[7:0], exp_nozero: f_nz[0]};
                        vectors.push_back(v);
                        names.push_back(name);
                end
                $fclose(fd);
                if (vectors.size() == 0)
                begin
                        abort_run("The vector file holds no vectors.");
                end
        endtask

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Drive one operation and wait for its result or the end of its window.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        task automatic run_vector(input int idx);
                vector_t       v;
                string         test;
                mac_operands_t ops;
                logic          starts;
                logic          gone;
                logic [31:0]   got_rd;
                logic          got_nozero;
                int            limit;
                int            pulses;
                int            pulse_cyc;
                v = vectors[idx];
                test = names[idx];
                starts = expect_start(v);
                limit = BASE_LATENCY + v.stall_n + SLACK_CYCLES;
                pulses = 0;
                pulse_cyc = -1;
                got_rd = '0;
                got_nozero = 1'b0;
                ops = '{rm: v.rm, rs: v.rs, rh: v.rh, rn: v.rn,
                        is_signed: op_is_signed(mac_op_t'(v.op))};
                for (int cyc = 0; cyc < limit; cyc++)
                begin
                        @(posedge i_clk);
                        gone = (v.clr != CLR_NONE) && (cyc > v.clr_at);   // Flushed upstream.
                        i_data_stall <= (cyc >= v.stall_at) && (cyc < v.stall_at + v.stall_n);
                        i_clear_from_writeback <= (v.clr == CLR_WB) && (cyc == v.clr_at);
                        i_clear_from_alu <= (v.clr == CLR_ALU) && (cyc == v.clr_at);
                        i_op <= gone ? MOV : mac_op_t'(v.op);
                        i_cc_satisfied <= gone ? 1'b0 : v.cc;
                        i_operands <= ops;
                        @(negedge i_clk);
                        // A started operation stays busy through its product steps.
                        if (cyc < BASE_LATENCY || !starts || gone)
                        begin
                                compare(test, "o_busy",
                                        starts && !gone && (cyc < BASE_LATENCY), o_busy);
                        end
                        if (o_result_valid)
                        begin
                                pulses++;
                                pulse_cyc = cyc;
                                got_rd = o_rd;
                                got_nozero = o_nozero;
                                break;
                        end
                end
                compare(test, "result count", v.exp_valid, pulses);
                if (pulses != 0)
                begin
                        compare(test, "o_rd", v.exp_rd, got_rd);
                        compare(test, "o_nozero", v.exp_nozero, got_nozero);
                        compare(test, "latency", BASE_LATENCY + v.stall_n, pulse_cyc);
                end
                @(posedge i_clk);
                i_op <= MOV;                                  // Back to an idle pipeline.
                i_cc_satisfied <= 1'b0;
                i_data_stall <= 1'b0;
                i_clear_from_writeback <= 1'b0;
                i_clear_from_alu <= 1'b0;
        endtask

        initial
        begin
                i_reset = 1'b1;
                i_clear_from_writeback = 1'b0;
                i_data_stall = 1'b0;
                i_clear_from_alu = 1'b0;
                i_cc_satisfied = 1'b0;
                i_op = MOV;
                i_operands = '0;
                load_vectors();
                watchdog_cycles = RESET_CYCLES + CYCLES_PER_VECTOR * vectors.size();
                foreach (vectors[i])
                begin
                        watchdog_cycles += vectors[i].stall_n;
                end
                watchdog_armed = 1'b1;
                repeat (RESET_CYCLES) @(posedge i_clk);
                i_reset <= 1'b0;
                @(negedge i_clk);
                compare("reset", "o_busy", 0, o_busy);
                compare("reset", "o_result_valid", 0, o_result_valid);
                compare("reset", "o_nozero", 0, o_nozero);
                foreach (vectors[i])
                begin
                        run_vector(i);
                end
                repeat (2) @(posedge i_clk);
                if (UUT.u_assertions.fail_count == 0)
                begin
                        $display("Result: PASSED");
                        $finish;
                end
                else
                begin
                        abort_run($sformatf("%0d concurrent assertion failures were reported.",
                                            UUT.u_assertions.fail_count));
                end
        end

        // Hang guard sized from the vector count and the stall cycles.
        initial
        begin
                wait (watchdog_armed);
                repeat (watchdog_cycles) @(posedge i_clk);
                abort_run($sformatf("Watchdog expired after %0d cycles and the DUT seems hung.",
                                    watchdog_cycles));
        end

endmodule

`default_nettype wire

/* dv/mac_unit_assertions.sv */
// Concurrent checks on result strobe, busy and nozero flag timing, bound into the unit.

`timescale 1ns/1ps
`default_nettype none

module mac_unit_assertions
(
        input wire logic i_clk,
        input wire logic i_reset,
        input wire logic i_clear_from_writeback,
        input wire logic i_data_stall,
        input wire logic i_clear_from_alu,
        input wire logic o_busy,
        input wire logic o_result_valid,
        input wire logic o_nozero
);

        int   fail_count = 0;          // Count of failed assertions.
        logic quiet;

        assign quiet = !i_data_stall && !i_clear_from_writeback && !i_clear_from_alu;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Result strobe shape.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        single_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
                o_result_valid |=> !o_result_valid)
        else
        begin
                $error("o_result_valid stayed high for more than one cycle.");
                fail_count++;
        end

        idle_on_result: assert property (@(posedge i_clk) disable iff (i_reset)
                o_result_valid |-> !o_busy)
        else
        begin
                $error("o_busy is high in the result cycle.");
                fail_count++;
        end

        nozero_with_result: assert property (@(posedge i_clk) disable iff (i_reset)
                o_nozero |-> o_result_valid)
        else
        begin
                $error("o_nozero is high without a result.");
                fail_count++;
        end

        // An undisturbed start gives its result on the fifth cycle.
        fixed_latency: assert property (@(posedge i_clk) disable iff (i_reset)
                ($rose(o_busy) && quiet) ##1 quiet [*4] |=> (o_result_valid || !quiet))
        else
        begin
                $error("o_result_valid missed the fifth cycle after an undisturbed start.");
                fail_count++;
        end

endmodule

bind mac_unit mac_unit_assertions u_assertions (.*);

`default_nettype wire

/* source/mac_unit.sv */
// Long multiply-accumulate unit top level joining sequencer and datapath blocks.

`timescale 1ns/1ps
`default_nettype none

module mac_unit
        import mac_op_pkg::*;
        import mac_types_pkg::*;
(
        input  wire logic          i_clk,
        input  wire logic          i_reset,

        // Pipeline strobes, in the order of their priority after reset.
        input  wire logic          i_clear_from_writeback,
        input  wire logic          i_data_stall,
        input  wire logic          i_clear_from_alu,

        input  wire mac_op_t       i_op,
        input  wire logic          i_cc_satisfied,
        input  wire mac_operands_t i_operands,  // Held steady until the result cycle.

        output logic [31:0]        o_rd,
        output logic               o_result_valid,
        output logic               o_busy,
        output logic               o_nozero
);

        mac_ctrl_t          ctrl;
        logic signed [63:0] product;
        mac_acc_u           acc_next;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Control.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        mac_sequencer u_sequencer (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear_from_writeback (i_clear_from_writeback),
                .i_data_stall           (i_data_stall),
                .i_clear_from_alu       (i_clear_from_alu),
                .i_cc_satisfied         (i_cc_satisfied),
                .i_op                   (i_op),
                .o_ctrl                 (ctrl),
                .o_busy                 (o_busy),
                .o_result_valid         (o_result_valid)
        );

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Datapath.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        mac_partial_product u_partial_product (
                .i_ctrl     (ctrl),
                .i_operands (i_operands),
                .o_product  (product)
        );

        mac_accumulator u_accumulator (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_ctrl     (ctrl),
                .i_operands (i_operands),
                .i_product  (product),
                .o_acc_next (acc_next)
        );

        mac_result_writer u_result_writer (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_ctrl     (ctrl),
                .i_acc_next (acc_next),
                .o_rd       (o_rd),
                .o_nozero   (o_nozero)
        );

endmodule

`default_nettype wire

/* source/mac_result_writer.sv */
// Result half selection, low-half buffer and nonzero flag for high-half operations.

`timescale 1ns/1ps
`default_nettype none

module mac_result_writer
        import mac_types_pkg::*;
(
        input  wire logic      i_clk,
        input  wire logic      i_reset,

        input  wire mac_ctrl_t i_ctrl,
        input  wire mac_acc_u  i_acc_next,

        output logic [31:0]    o_rd,
        output logic           o_nozero
);

        logic [31:0] buffer_ff;
        logic        in_add;

        assign in_add = (i_ctrl.step == STEP_ADD);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Result word and flag, both only in the add step.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        always_comb
        begin
                o_rd     = 32'd0;
                o_nozero = 1'b0;
                if (in_add)
                begin
                        o_rd = i_ctrl.high ? i_acc_next.halves.hi
                                           : i_acc_next.halves.lo;
                        // Report on the low half kept from the earlier operation.
                        o_nozero = i_ctrl.high && i_ctrl.advance && (buffer_ff != 32'd0);
                end
        end

        // Low-half operations leave their result here for the following high half.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_ctrl.flush)
                begin
                        buffer_ff <= 32'd0;
                end
                else if (i_ctrl.advance && in_add && !i_ctrl.high)
                begin
                        buffer_ff <= i_acc_next.halves.lo;
                end
        end

endmodule

`default_nettype wire

/* source/mac_accumulator.sv */
// 64-bit running sum of aligned partial products and the final addend.

`timescale 1ns/1ps
`default_nettype none

module mac_accumulator
        import mac_types_pkg::*;
(
        input  wire logic               i_clk,
        input  wire logic               i_reset,

        input  wire mac_ctrl_t          i_ctrl,
        input  wire mac_operands_t      i_operands,
        input  wire logic signed [63:0] i_product,

        output mac_acc_u                o_acc_next
);

        logic signed [63:0] acc_ff;
        logic signed [63:0] acc_nxt;
        logic signed [63:0] addend;

        assign addend = {i_operands.rh, i_operands.rn};

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Next value of the sum for the current step.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        always_comb
        begin
                case (i_ctrl.step)
                STEP_IDLE: acc_nxt = '0;                // Start each operation from zero.
                STEP_ADD:  acc_nxt = acc_ff + addend;
                default:   acc_nxt = acc_ff + i_product;
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_ctrl.flush)
                begin
                        acc_ff <= '0;
                end
                else if (i_ctrl.advance)
                begin
                        acc_ff <= acc_nxt;
                end
                // A stall holds the partial sum.
        end

        // The writer sees the completed sum during the add step.
        assign o_acc_next.sum = acc_nxt;

endmodule

`default_nettype wire

/* source/mac_partial_product.sv */
// Half-word selection, sign extension and aligned 17x17 partial product per step.

`timescale 1ns/1ps
`default_nettype none

module mac_partial_product
        import mac_types_pkg::*;
(
        input  wire mac_ctrl_t     i_ctrl,
        input  wire mac_operands_t i_operands,
        output logic signed [63:0] o_product
);

        logic signed [16:0] rm_hi;
        logic signed [16:0] rs_hi;
        logic signed [16:0] rm_lo;
        logic signed [16:0] rs_lo;
        logic signed [16:0] in_a;
        logic signed [16:0] in_b;
        logic signed [33:0] prod;
        logic signed [63:0] prod_wide;

        // Upper halves carry the operand sign only for signed operations.
        assign rm_hi = i_operands.is_signed ? {i_operands.rm[31], i_operands.rm[31:16]}
                                            : {1'b0, i_operands.rm[31:16]};
        assign rs_hi = i_operands.is_signed ? {i_operands.rs[31], i_operands.rs[31:16]}
                                            : {1'b0, i_operands.rs[31:16]};
        assign rm_lo = {1'b0, i_operands.rm[15:0]};     // Always positive.
        assign rs_lo = {1'b0, i_operands.rs[15:0]};

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // One shared multiplier; the step picks its inputs.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        always_comb
        begin
                in_a = rm_lo;
                in_b = rs_lo;
                case (i_ctrl.step)
                STEP_HL:
                begin
                        in_a = rm_hi;
                        in_b = rs_lo;
                end
                STEP_LH:
                begin
                        in_a = rm_lo;
                        in_b = rs_hi;
                end
                STEP_HH:
                begin
                        in_a = rm_hi;
                        in_b = rs_hi;
                end
                default: ;                              // LL and unused steps.
                endcase
        end

        assign prod      = in_a * in_b;
        assign prod_wide = {{30{prod[33]}}, prod};      // Sign extend to 64 bits.

        // Align the product to the weight of its halves.
        always_comb
        begin
                case (i_ctrl.step)
                STEP_LL: o_product = prod_wide;
                STEP_HL: o_product = prod_wide <<< 16;
                STEP_LH: o_product = prod_wide <<< 16;
                STEP_HH: o_product = prod_wide <<< 32;
                default: o_product = '0;                // Nothing to add in idle or add.
                endcase
        end

endmodule

`default_nettype wire

/* source/mac_sequencer.sv */
// Control FSM for the partial product steps, with stall and flush decoding.

`timescale 1ns/1ps
`default_nettype none

module mac_sequencer
        import mac_op_pkg::*;
        import mac_types_pkg::*;
(
        input  wire logic      i_clk,
        input  wire logic      i_reset,

        input  wire logic      i_clear_from_writeback,
        input  wire logic      i_data_stall,
        input  wire logic      i_clear_from_alu,

        input  wire logic      i_cc_satisfied,
        input  wire mac_op_t   i_op,

        output mac_ctrl_t      o_ctrl,
        output logic           o_busy,
        output logic           o_result_valid
);

        mac_step_t step_ff;
        mac_step_t step_nxt;
        logic      clear_req;
        logic      advance;
        logic      flush;
        logic      start;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Reset ranks first, then the writeback clear, the stall and the ALU clear.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        assign clear_req = i_clear_from_writeback || (!i_data_stall && i_clear_from_alu);
        assign flush     = !i_reset && clear_req;
        assign advance   = !i_reset && !i_clear_from_writeback && !i_data_stall &&
                           !i_clear_from_alu;

        assign start = i_cc_satisfied && op_is_long_mul(i_op);

        always_comb
        begin
                step_nxt = step_ff;
                case (step_ff)
                STEP_IDLE: if (start) step_nxt = STEP_LL;
                STEP_LL:   step_nxt = STEP_HL;
                STEP_HL:   step_nxt = STEP_LH;
                STEP_LH:   step_nxt = STEP_HH;
                STEP_HH:   step_nxt = STEP_ADD;
                default:   step_nxt = STEP_IDLE;   // The add step ends the operation.
                endcase
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset || flush)
                begin
                        step_ff <= STEP_IDLE;
                end
                else if (advance)
                begin
                        step_ff <= step_nxt;
                end
        end

        // Busy covers the start cycle and the four product steps.
        always_comb
        begin
                case (step_ff)
                STEP_IDLE: o_busy = start;
                STEP_ADD:  o_busy = 1'b0;
                default:   o_busy = 1'b1;
                endcase
        end

        // A stalled or cleared add cycle does not deliver its result.
        assign o_result_valid = (step_ff == STEP_ADD) && !i_data_stall && !clear_req;

        assign o_ctrl.step    = step_ff;
        assign o_ctrl.advance = advance;
        assign o_ctrl.flush   = flush;
        assign o_ctrl.high    = op_is_high(i_op);

endmodule

`default_nettype wire

/* source/mac_types_pkg.sv */
// Datapath types: step enum, operand struct, accumulator union and control struct.

`default_nettype none

package mac_types_pkg;

        // Sequencer steps. LL, HL, LH and HH name the halves of rm and rs in that order.
        typedef enum logic [2:0] {
                STEP_IDLE = 3'd0,
                STEP_LL   = 3'd1,      // rm low  times rs low.
                STEP_HL   = 3'd2,      // rm high times rs low.
                STEP_LH   = 3'd3,      // rm low  times rs high.
                STEP_HH   = 3'd4,      // rm high times rs high.
                STEP_ADD  = 3'd5       // Addend and result cycle.
        } mac_step_t;

        // Source operands as read from the register file.
        typedef struct packed {
                logic [31:0] rm;
                logic [31:0] rs;
                logic [31:0] rh;        // Upper word of the addend.
                logic [31:0] rn;        // Lower word of the addend.
                logic        is_signed;
        } mac_operands_t;

        typedef struct packed {
                logic [31:0] hi;
                logic [31:0] lo;
        } mac_halves_t;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // The accumulator word is an arithmetic sum for the adder and a pair of
        // result words for the writer.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        typedef union packed {
                logic signed [63:0] sum;
                mac_halves_t        halves;
        } mac_acc_u;

        // Control word from the sequencer to the datapath blocks.
        typedef struct packed {
                mac_step_t step;
                logic      advance;     // Registers may load this cycle.
                logic      flush;       // Registers return to zero.
                logic      high;        // Operation returns the high half.
        } mac_ctrl_t;

endpackage

`default_nettype wire

/* source/mac_op_pkg.sv */
// Execute-stage operation codes and long multiply classification functions.

`default_nettype none

package mac_op_pkg;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Operation codes, fixed by the instruction encoding.
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        typedef enum logic [4:0] {
                AND    = 5'h00,
                EOR    = 5'h01,
                SUB    = 5'h02,
                ADD    = 5'h04,
                ORR    = 5'h0C,
                MOV    = 5'h0D,
                UMLALL = 5'h14,        // Unsigned, low half of the result.
                UMLALH = 5'h15,        // Unsigned, high half of the result.
                SMLALL = 5'h16,        // Signed, low half.
                SMLALH = 5'h17         // Signed, high half.
        } mac_op_t;

        // True for any of the four long multiply-accumulate codes.
        function automatic logic op_is_long_mul(input mac_op_t op);
                return op inside {UMLALL, UMLALH, SMLALL, SMLALH};
        endfunction

        // Signed variants treat the upper operand halves as two's complement.
        function automatic logic op_is_signed(input mac_op_t op);
                return op inside {SMLALL, SMLALH};
        endfunction

        function automatic logic op_is_high(input mac_op_t op);
                return op_is_long_mul(op) && op[0]; // Bit 0 picks the high word.
        endfunction

endpackage

`default_nettype wire
